/* Bender.yml */
package:
  name: adc_rx

sources:
  - logic/adc_rx_pkg.sv
  - logic/lrck_framer.sv
  - logic/lane_deserializer.sv
  - logic/frame_sequencer.sv
  - logic/sample_fifo.sv
  - logic/adc_rx_top.sv
  - target: test
    files:
      - bench/adc_rx_assertions.sv
      - bench/adc_rx_tb.sv

/* bench/adc_rx_assertions.sv */
`timescale 1ns/1ps

module adc_rx_assertions (
    input logic                               adc_pbck,
    input logic                               reset,
    input logic                               chan,
    input logic                               out_valid,
    input logic                               out_ready,
    input logic [adc_rx_pkg::SAMPLE_BITS-1:0] out_data,
    input adc_rx_pkg::chan_t                  out_channel,
    input logic                               overflow
);

    int fail_count = 0;

    // A word on offer stays put until the consumer takes it
    hold_until_ready: assert property (@(posedge adc_pbck) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_channel))
    else begin
        fail_count++;
        $error("out_valid or its word changed before out_ready");
    end

    overflow_sticky: assert property (@(posedge adc_pbck) disable iff (reset)
        overflow |=> overflow)
    else begin
        fail_count++;
        $error("overflow fell without reset");
    end

    empty_after_reset: assert property (@(posedge adc_pbck) reset |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high in the cycle after reset");
    end

    // Two channel mode only carries L0 and R0
    two_channel_range: assert property (@(posedge adc_pbck) disable iff (reset)
        !chan && out_valid |-> out_channel < 2)
    else begin
        fail_count++;
        $error("out_channel above 1 in two channel mode");
    end

endmodule

/* bench/adc_rx_tb.sv */
`timescale 1ns/1ps

module adc_rx_tb;

    localparam int FIFO_DEPTH   = 16;
    localparam int TOTAL_FRAMES = 34;

    logic              adc_pbck;
    logic              reset;
    logic              adc_plrck;
    logic [3:0]        adc_pdata;
    adc_rx_pkg::fmt_t  fmt;
    logic              chan;
    logic              rec_enable;
    logic              out_ready;
    logic              out_valid;
    logic [23:0]       out_data;
    adc_rx_pkg::chan_t out_channel;
    logic              overflow;

    logic [31:0]       lfsr_state;
    logic [31:0]       half_bits [2][4];
    logic [23:0]       exp_data [$];
    adc_rx_pkg::chan_t exp_chan [$];
    logic              exp_droppable [$];
    logic              random_ready;
    logic              ready_level;
    logic              drop_phase;
    int                drop_words;
    int                skipped;
    int                checked;
    int                mismatch_errors;
    int                other_errors;
    int                total_errors;

    adc_rx_top #(.LANES(4), .FIFO_DEPTH(FIFO_DEPTH)) adc_rx_top_i (.*);

    bind adc_rx_top adc_rx_assertions asrt_i (
        .adc_pbck(adc_pbck), .reset(reset), .chan(chan), .out_valid(out_valid),
        .out_ready(out_ready), .out_data(out_data), .out_channel(out_channel),
        .overflow(overflow)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic next_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // Sample from the 32 slots of one half with its MSB in the format's first capture slot
    function automatic logic [23:0] expected_sample(input logic [31:0] bits,
                                                    input adc_rx_pkg::fmt_t f);
        int first;
        logic [23:0] s;
        case (f)
            adc_rx_pkg::fmt_i2s: first = 1;
            adc_rx_pkg::fmt_lj:  first = 0;
            default:             first = adc_rx_pkg::SLOT_BITS - adc_rx_pkg::SAMPLE_BITS;
        endcase
        s = '0;
        for (int k = 0; k < adc_rx_pkg::SAMPLE_BITS; k++) s = {s[22:0], bits[first + k]};
        return s;
    endfunction

    // Channel 2k is lane k left, 2k+1 is lane k right
    // Frames driven while the consumer stalls may be cut short
    task automatic push_frame(input adc_rx_pkg::fmt_t f, input logic eight);
        for (int lane = 0; lane < (eight ? 4 : 1); lane++) begin
            for (int side = 0; side < 2; side++) begin
                exp_data.push_back(expected_sample(half_bits[side][lane], f));
                exp_chan.push_back(adc_rx_pkg::chan_t'(2 * lane + side));
                exp_droppable.push_back(!ready_level);
            end
        end
    endtask

    // Left half then right half; fmt changes at the left start, chan at slot 16
    task automatic drive_frame(input adc_rx_pkg::fmt_t f, input logic chan_val,
                               input int en_pos, input logic en_val);
        logic frame_en;
        for (int h = 0; h < 2; h++) begin
            for (int pos = 0; pos < 32; pos++) begin
                @(posedge adc_pbck);
                #1;
                adc_plrck = (h == 1);
                if (h * 32 + pos == en_pos) rec_enable = en_val;
                if (h == 0 && pos == 0) begin
                    fmt      = f;
                    frame_en = rec_enable;
                end
                if (h == 0 && pos == 16) chan = chan_val;
                for (int lane = 0; lane < 4; lane++) begin
                    half_bits[h][lane][pos] = next_bit();
                    adc_pdata[lane]         = half_bits[h][lane][pos];
                end
                if (random_ready) out_ready = next_bit();
                else out_ready = ready_level;
            end
        end
        if (frame_en) push_frame(f, chan);
    endtask

    task automatic check_output();
        if (drop_phase && drop_words >= FIFO_DEPTH) begin
            // Cut frames leave gaps, so step over words that never came out
            while (exp_data.size() != 0 && exp_droppable[0] &&
                   (exp_data[0] != out_data || exp_chan[0] != out_channel)) begin
                void'(exp_data.pop_front());
                void'(exp_chan.pop_front());
                void'(exp_droppable.pop_front());
                skipped++;
            end
        end
        if (exp_data.size() == 0) begin
            other_errors++;
            $display("%0t: a word on channel %0d came out with no expected word left",
                     $time, out_channel);
            return;
        end
        if (out_channel !== exp_chan[0]) begin
            mismatch_errors++;
            $display("CHECK FAILED at %0t: out_channel expected %0d, got %0d",
                     $time, exp_chan[0], out_channel);
        end
        if (out_data !== exp_data[0]) begin
            mismatch_errors++;
            $display("CHECK FAILED at %0t: out_data expected %06h, got %06h",
                     $time, exp_data[0], out_data);
        end
        void'(exp_data.pop_front());
        void'(exp_chan.pop_front());
        void'(exp_droppable.pop_front());
        checked++;
        if (drop_phase) drop_words++;
    endtask

    // Compare each transfer on the falling edge
    always @(negedge adc_pbck) begin
        if (reset === 1'b0 && out_valid === 1'b1 && out_ready === 1'b1) check_output();
    end

    initial begin
        adc_pbck = 1'b0;
        forever #4 adc_pbck = ~adc_pbck;
    end

    initial begin
        #(TOTAL_FRAMES * 64 * 8 * 2);
        $display("Timeout: the run did not finish within %0d frame times", TOTAL_FRAMES * 2);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        lfsr_state      = 32'h9b8c_7f34;
        reset           = 1'b1;
        adc_plrck       = 1'b1;
        adc_pdata       = '0;
        fmt             = adc_rx_pkg::fmt_i2s;
        chan            = 1'b0;
        rec_enable      = 1'b0;
        out_ready       = 1'b1;
        random_ready    = 1'b0;
        ready_level     = 1'b1;
        drop_phase      = 1'b0;
        drop_words      = 0;
        skipped         = 0;
        checked         = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        repeat (2) @(posedge adc_pbck);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge adc_pbck);

        // I2S on two channels
        for (int i = 0; i < 4; i++) drive_frame(adc_rx_pkg::fmt_i2s, 1'b0, 0, 1'b1);
        for (int i = 0; i < 6; i++) begin
            drive_frame(i < 3 ? adc_rx_pkg::fmt_lj : adc_rx_pkg::fmt_rj, 1'b0, 0, 1'b1);
        end

        // Enable moves inside frames and only the next left start sees it
        drive_frame(adc_rx_pkg::fmt_i2s, 1'b0, 20, 1'b0);
        drive_frame(adc_rx_pkg::fmt_lj, 1'b0, 45, 1'b1);
        drive_frame(adc_rx_pkg::fmt_rj, 1'b0, 10, 1'b0);
        drive_frame(adc_rx_pkg::fmt_i2s, 1'b0, 0, 1'b1);

        // Eight channels, then a consumer that is ready about half the time
        for (int i = 0; i < 4; i++) drive_frame(adc_rx_pkg::fmt_t'(i % 3), 1'b1, 0, 1'b1);
        random_ready = 1'b1;
        for (int i = 0; i < 6; i++) drive_frame(adc_rx_pkg::fmt_t'((i + 1) % 3), 1'b1, 0, 1'b1);
        random_ready = 1'b0;
        if (overflow !== 1'b0) begin
            mismatch_errors++;
            $display("CHECK FAILED at %0t: overflow expected 0, got %b", $time, overflow);
        end

        // Consumer stalled long enough to fill the FIFO and cut frames
        drop_phase  = 1'b1;
        ready_level = 1'b0;
        for (int i = 0; i < 5; i++) drive_frame(adc_rx_pkg::fmt_i2s, 1'b1, 0, 1'b1);
        ready_level = 1'b1;
        for (int i = 0; i < 3; i++) drive_frame(adc_rx_pkg::fmt_lj, 1'b1, 0, 1'b1);
        for (int i = 0; i < 2; i++) drive_frame(adc_rx_pkg::fmt_i2s, 1'b1, 0, 1'b0);

        while (exp_data.size() != 0 || out_valid !== 1'b0) @(negedge adc_pbck);
        if (overflow !== 1'b1) begin
            mismatch_errors++;
            $display("CHECK FAILED at %0t: overflow expected 1, got %b", $time, overflow);
        end
        if (skipped == 0) begin
            other_errors++;
            $display("No words went missing while the FIFO was held full");
        end
        total_errors = mismatch_errors + other_errors + adc_rx_top_i.asrt_i.fail_count;
        $display("Errors: mismatch %0d, other %0d, assertion %0d; words checked %0d",
                 mismatch_errors, other_errors, adc_rx_top_i.asrt_i.fail_count, checked);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* logic/adc_rx_pkg.sv */
package adc_rx_pkg;

    // Framing formats, encoded as the converter's format pins
    typedef enum logic [1:0] {
        fmt_rj  = 2'b00,
        fmt_lj  = 2'b01,
        fmt_i2s = 2'b10
    } fmt_t;

    // Bit clocks in each LRCK half
    localparam int SLOT_BITS = 32;

    // Sample width on the line and at the output
    localparam int SAMPLE_BITS = 24;

    // Data lanes on the connector
    localparam int MAX_LANES = 4;

    // Bit position within one LRCK half, 0 to 31
    typedef logic [4:0] pos_t;

    // Channel index within a frame, 0 to 7
    typedef logic [2:0] chan_t;

endpackage

/* logic/adc_rx_top.sv */
`timescale 1ns/1ps

module adc_rx_top #(
    parameter int LANES      = adc_rx_pkg::MAX_LANES,
    parameter int FIFO_DEPTH = 16
) (
    input  logic              adc_pbck,
    input  logic              reset,
    input  logic              adc_plrck,
    input  logic [3:0]        adc_pdata,
    input  adc_rx_pkg::fmt_t  fmt,
    input  logic              chan,
    input  logic              rec_enable,
    input  logic              out_ready,
    output logic              out_valid,
    output logic [adc_rx_pkg::SAMPLE_BITS-1:0] out_data,
    output adc_rx_pkg::chan_t out_channel,
    output logic              overflow
);

    logic                                              half_start;
    logic                                              left;
    adc_rx_pkg::pos_t                                  bit_pos;
    adc_rx_pkg::fmt_t                                  fmt_frame;
    logic                                              frame_done;
    logic                                              frame_enabled;
    logic [LANES-1:0][1:0][adc_rx_pkg::SAMPLE_BITS-1:0] frame_words;
    logic                                              wr_valid;
    logic                                              wr_ready;
    logic [adc_rx_pkg::SAMPLE_BITS-1:0]                wr_data;
    adc_rx_pkg::chan_t                                 wr_channel;
    logic                                              drop;

    lrck_framer framer_i (
        .adc_pbck(adc_pbck), .reset(reset), .adc_plrck(adc_plrck), .fmt(fmt),
        .rec_enable(rec_enable), .half_start(half_start), .left(left), .bit_pos(bit_pos),
        .fmt_frame(fmt_frame), .frame_done(frame_done), .frame_enabled(frame_enabled)
    );

    lane_deserializer #(.LANES(LANES)) deser_i (
        .adc_pbck(adc_pbck), .reset(reset), .adc_pdata(adc_pdata),
        .half_start(half_start), .left(left), .bit_pos(bit_pos), .fmt_frame(fmt_frame),
        .frame_done(frame_done), .frame_words(frame_words)
    );

    frame_sequencer #(.LANES(LANES)) seq_i (
        .adc_pbck(adc_pbck), .reset(reset), .chan(chan), .frame_done(frame_done),
        .frame_enabled(frame_enabled), .frame_words(frame_words), .wr_valid(wr_valid),
        .wr_ready(wr_ready), .wr_data(wr_data), .wr_channel(wr_channel), .drop(drop)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .adc_pbck(adc_pbck), .reset(reset), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_data(wr_data), .wr_channel(wr_channel), .drop(drop), .out_valid(out_valid),
        .out_ready(out_ready), .out_data(out_data), .out_channel(out_channel),
        .overflow(overflow)
    );

endmodule

/* logic/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int LANES = adc_rx_pkg::MAX_LANES
) (
    input  logic              adc_pbck,
    input  logic              reset,
    input  logic              chan,
    input  logic              frame_done,
    input  logic              frame_enabled,
    input  logic [LANES-1:0][1:0][adc_rx_pkg::SAMPLE_BITS-1:0] frame_words,
    output logic              wr_valid,
    input  logic              wr_ready,
    output logic [adc_rx_pkg::SAMPLE_BITS-1:0] wr_data,
    output adc_rx_pkg::chan_t wr_channel,
    output logic              drop
);

    logic              pend;
    logic              more;
    logic              accept;
    logic              load_first;
    logic              load_next;
    logic              more_after;
    logic              lost;
    adc_rx_pkg::chan_t idx;
    adc_rx_pkg::chan_t last;

    assign accept = wr_valid && wr_ready;

    // First word waits until the output register is free
    assign load_first = pend && (!wr_valid || accept);
    assign load_next  = !load_first && accept && more;

    always_comb begin
        if (load_first) begin
            more_after = 1'b1;
        end else if (load_next) begin
            more_after = (idx != last);
        end else begin
            more_after = more;
        end
    end

    // Words still owed when a new frame overwrites frame_words
    assign lost = more_after || (pend && !load_first);

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            wr_valid <= 1'b0;
            pend     <= 1'b0;
            more     <= 1'b0;
            drop     <= 1'b0;
            idx      <= '0;
            last     <= '0;
        end else begin
            drop <= 1'b0;
            more <= more_after;
            if (accept) begin
                wr_valid <= 1'b0;
            end
            if (load_first) begin
                wr_valid   <= 1'b1;
                wr_data    <= frame_words[0][0];
                wr_channel <= '0;
                idx        <= adc_rx_pkg::chan_t'(1);
                last       <= chan ? adc_rx_pkg::chan_t'(2 * LANES - 1) : adc_rx_pkg::chan_t'(1);
                pend       <= 1'b0;
            end else if (load_next) begin
                wr_valid   <= 1'b1;
                wr_data    <= frame_words[idx[2:1]][idx[0]];
                wr_channel <= idx;
                idx        <= idx + 1'b1;
            end
            // A held word still goes out, the rest of the old frame does not
            if (frame_done) begin
                pend <= frame_enabled;
                more <= 1'b0;
                drop <= lost;
            end
        end
    end

endmodule

/* logic/lane_deserializer.sv */
`timescale 1ns/1ps

module lane_deserializer #(
    parameter int LANES = adc_rx_pkg::MAX_LANES
) (
    input  logic             adc_pbck,
    input  logic             reset,
    input  logic [3:0]       adc_pdata,
    input  logic             half_start,
    input  logic             left,
    input  adc_rx_pkg::pos_t bit_pos,
    input  adc_rx_pkg::fmt_t fmt_frame,
    input  logic             frame_done,
    output logic [LANES-1:0][1:0][adc_rx_pkg::SAMPLE_BITS-1:0] frame_words
);

    localparam int SW       = adc_rx_pkg::SAMPLE_BITS;
    localparam int RJ_FIRST = adc_rx_pkg::SLOT_BITS - adc_rx_pkg::SAMPLE_BITS;

    logic          capture;
    logic          clear;
    logic [SW-1:0] left_work  [LANES];
    logic [SW-1:0] right_work [LANES];
    logic [SW-1:0] left_done  [LANES];

    // Capture window by format, MSB first
    always_comb begin
        case (fmt_frame)
            adc_rx_pkg::fmt_i2s: capture = (bit_pos >= 1) && (bit_pos <= SW);
            adc_rx_pkg::fmt_lj:  capture = (bit_pos <= SW - 1);
            adc_rx_pkg::fmt_rj:  capture = (bit_pos >= RJ_FIRST);
            default:             capture = 1'b0;
        endcase
    end

    assign clear = half_start || reset;

    function automatic logic [SW-1:0] shift_in(
        input logic [SW-1:0] word,
        input logic          wipe,
        input logic          take,
        input logic          bit_in
    );
        logic [SW-1:0] base;
        base = wipe ? '0 : word;
        if (take) begin
            return {base[SW-2:0], bit_in};
        end
        return base;
    endfunction

    always_ff @(posedge adc_pbck) begin
        for (int i = 0; i < LANES; i++) begin
            if (left) begin
                left_work[i] <= shift_in(left_work[i], clear, capture, adc_pdata[i]);
            end else begin
                right_work[i] <= shift_in(right_work[i], clear, capture, adc_pdata[i]);
            end

            // Left word is finished once the right half begins
            if (half_start && !left) begin
                left_done[i] <= left_work[i];
            end

            // Right word stays intact until the next right half
            if (frame_done) begin
                frame_words[i][0] <= left_done[i];
                frame_words[i][1] <= right_work[i];
            end
        end
    end

endmodule

/* logic/lrck_framer.sv */
`timescale 1ns/1ps

module lrck_framer (
    input  logic             adc_pbck,
    input  logic             reset,
    input  logic             adc_plrck,
    input  adc_rx_pkg::fmt_t fmt,
    input  logic             rec_enable,
    output logic             half_start,
    output logic             left,
    output adc_rx_pkg::pos_t bit_pos,
    output adc_rx_pkg::fmt_t fmt_frame,
    output logic             frame_done,
    output logic             frame_enabled
);

    logic             lrck_last;
    logic             primed;
    logic             left_start;
    logic             in_frame;
    logic             right_seen;
    logic             en_cur;
    adc_rx_pkg::pos_t pos_q;
    adc_rx_pkg::fmt_t fmt_q;

    // An edge only counts once a previous level has been seen
    assign half_start = primed && (adc_plrck != lrck_last);
    assign left       = !adc_plrck;
    assign left_start = half_start && left;

    // Position 0 on the edge itself, then count up and hold at the last slot bit
    always_comb begin
        if (half_start) begin
            bit_pos = '0;
        end else if (pos_q == adc_rx_pkg::pos_t'(adc_rx_pkg::SLOT_BITS - 1)) begin
            bit_pos = pos_q;
        end else begin
            bit_pos = pos_q + 1'b1;
        end
    end

    // The new format already applies at position 0 of the left half
    assign fmt_frame = left_start ? fmt : fmt_q;

    always_ff @(posedge adc_pbck) begin
        lrck_last <= adc_plrck;
        if (reset) begin
            primed        <= 1'b0;
            pos_q         <= '1;
            fmt_q         <= adc_rx_pkg::fmt_i2s;
            en_cur        <= 1'b0;
            in_frame      <= 1'b0;
            right_seen    <= 1'b0;
            frame_done    <= 1'b0;
            frame_enabled <= 1'b0;
        end else begin
            primed     <= 1'b1;
            pos_q      <= bit_pos;
            frame_done <= 1'b0;
            if (left_start) begin
                // Close the previous pair and open a new frame
                frame_done    <= in_frame && right_seen;
                frame_enabled <= en_cur;
                en_cur        <= rec_enable;
                fmt_q         <= fmt;
                in_frame      <= 1'b1;
                right_seen    <= 1'b0;
            end else if (half_start) begin
                right_seen <= in_frame;
            end
        end
    end

endmodule

/* logic/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              adc_pbck,
    input  logic              reset,
    input  logic              wr_valid,
    output logic              wr_ready,
    input  logic [adc_rx_pkg::SAMPLE_BITS-1:0] wr_data,
    input  adc_rx_pkg::chan_t wr_channel,
    input  logic              drop,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [adc_rx_pkg::SAMPLE_BITS-1:0] out_data,
    output adc_rx_pkg::chan_t out_channel,
    output logic              overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [adc_rx_pkg::SAMPLE_BITS-1:0] data_mem [FIFO_DEPTH];
    adc_rx_pkg::chan_t                  chan_mem [FIFO_DEPTH];
    logic [AW:0]                        wr_ptr;
    logic [AW:0]                        rd_ptr;
    logic                               full;

    // Extra pointer bit tells full from empty
    assign full        = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ready    = !full;
    assign out_valid   = (wr_ptr != rd_ptr);
    assign out_data    = data_mem[rd_ptr[AW-1:0]];
    assign out_channel = chan_mem[rd_ptr[AW-1:0]];

    always_ff @(posedge adc_pbck) begin
        if (wr_valid && wr_ready) begin
            data_mem[wr_ptr[AW-1:0]] <= wr_data;
            chan_mem[wr_ptr[AW-1:0]] <= wr_channel;
        end
    end

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Sticky until reset
            if (drop) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

/* vlog.f */
logic/adc_rx_pkg.sv
logic/lrck_framer.sv
logic/lane_deserializer.sv
logic/frame_sequencer.sv
logic/sample_fifo.sv
logic/adc_rx_top.sv
bench/adc_rx_assertions.sv
bench/adc_rx_tb.sv
